//--- dv/ipod_sva.sv
`default_nettype none

module ipod_sva
  import ipod_pkg::*;
#(
  parameter bit      HAS_FLASH = 1'b0,
  parameter bit      HAS_RATE  = 1'b0,
  parameter period_t MIN_P     = 16'd0,
  parameter period_t MAX_P     = 16'hFFFF
)
(
  input wire         CLK_50M,
  input wire         rst_n,
  input wire         flash_read,
  input flash_addr_t flash_address,
  input wire         flash_waitrequest,
  input wire         sample_tick,
  input period_t     sample_period
);
  timeunit 1ns;
  timeprecision 1ps;

  // ====================
  // Flash bus
  // ====================

  hold_read: assert property (@(posedge CLK_50M) disable iff (!rst_n || !HAS_FLASH)
    (flash_read && flash_waitrequest) |=> (flash_read && $stable(flash_address)))
    else $error("flash read dropped or address moved under waitrequest");

  drop_read: assert property (@(posedge CLK_50M) disable iff (!rst_n || !HAS_FLASH)
    (flash_read && !flash_waitrequest) |=> !flash_read)
    else $error("flash read held after acceptance");

  // ====================
  // Rate generator
  // ====================

  tick_single: assert property (@(posedge CLK_50M) disable iff (!rst_n || !HAS_RATE)
    sample_tick |=> !sample_tick)
    else $error("sample strobe longer than one cycle");

  period_range: assert property (@(posedge CLK_50M) disable iff (!rst_n || !HAS_RATE)
    (sample_period >= MIN_P) && (sample_period <= MAX_P))
    else $error("sample period outside its limits");

endmodule

bind sample_fetch ipod_sva #(.HAS_FLASH(1'b1)) u_fetch_sva (
  .CLK_50M           (CLK_50M),
  .rst_n             (rst_n),
  .flash_read        (flash_read),
  .flash_address     (flash_address),
  .flash_waitrequest (flash_waitrequest),
  .sample_tick       (1'b0),
  .sample_period     (16'd0)
);

bind rate_gen ipod_sva #(.HAS_RATE(1'b1), .MIN_P(MIN_PERIOD), .MAX_P(MAX_PERIOD)) u_rate_sva (
  .CLK_50M           (CLK_50M),
  .rst_n             (rst_n),
  .flash_read        (1'b0),
  .flash_address     (23'd0),
  .flash_waitrequest (1'b1),
  .sample_tick       (sample_tick),
  .sample_period     (sample_period)
);

`default_nettype wire

//--- dv/tb_simple_ipod.sv
`default_nettype none

module tb_simple_ipod
  import ipod_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam flash_addr_t LAST_ADDR = 23'd63;
  localparam period_t DEF_PERIOD = 16'd100;
  localparam period_t STEP = 16'd8;
  localparam period_t MIN_P = 16'd64;
  localparam period_t MAX_P = 16'd160;
  localparam int REFRESH = 40;

  localparam int WRAP_SAMPLES = 2 * (int'(LAST_ADDR) + 1) + 12;  // Past one full wrap
  localparam int RESTART_SAMPLES = 6;
  localparam int PLAY_SAMPLES = 2 * WRAP_SAMPLES + 2 * RESTART_SAMPLES + 8;
  localparam int PAUSE_CYCLES = 6 * int'(DEF_PERIOD);
  localparam int SPEED_CYCLES = 24 * (REFRESH + 2);
  localparam int TEST_CYCLES = (PLAY_SAMPLES + 8) * int'(DEF_PERIOD) + 5 * PAUSE_CYCLES
                               + SPEED_CYCLES + 400;
  localparam longint WATCHDOG_NS = 2 * longint'(TEST_CYCLES) * 20;  // Twice the expected length

  logic        CLK_50M = 1'b0;
  logic        rst_n;
  ascii_t      kbd_code;
  logic        kbd_strobe;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  logic        flash_read;
  flash_addr_t flash_address;
  logic        flash_waitrequest;
  logic        flash_readdatavalid;
  flash_word_t flash_readdata;
  sample_t     audio_sample;
  logic        audio_valid;
  seg_t        hex0, hex1, hex2, hex3, hex4, hex5;

  logic [31:0] lfsr = 32'h72346bea;
  int          valid_count = 0;
  period_t     exp_period = DEF_PERIOD;

  // Reference model state
  flash_addr_t m_addr = '0;
  flash_word_t m_word = '0;
  bit          m_buffered = 1'b0;
  bit          m_second_upper = 1'b0;
  bit          m_rst_pend = 1'b1;  // First word comes from the song edge
  bit          m_forward = 1'b1;

  simple_ipod #(
    .SONG_LAST_ADDR (LAST_ADDR),
    .DEFAULT_PERIOD (DEF_PERIOD),
    .SPEED_STEP     (STEP),
    .MIN_PERIOD     (MIN_P),
    .MAX_PERIOD     (MAX_P),
    .REFRESH_CYCLES (REFRESH)
  ) UUT (.*);

  always #10 CLK_50M = ~CLK_50M;

  // ====================
  // Reference functions
  // ====================

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic flash_word_t flash_word(input flash_addr_t a);
    logic [15:0] hi;
    hi = a[15:0] ^ 16'(a[ADDR_W-1:16]) ^ 16'hA5A5;  // Upper address bits folded in
    return {hi, ~hi};
  endfunction

  function automatic sample_t expected_sample();
    if (m_buffered)
    begin
      m_buffered = 1'b0;
      return m_second_upper ? m_word[31:16] : m_word[15:0];
    end
    if (m_rst_pend)
      m_addr = m_forward ? '0 : LAST_ADDR;
    else if (m_forward)
      m_addr = (m_addr == LAST_ADDR) ? '0 : m_addr + flash_addr_t'(1);
    else
      m_addr = (m_addr == '0) ? LAST_ADDR : m_addr - flash_addr_t'(1);
    m_rst_pend = 1'b0;
    m_word = flash_word(m_addr);
    m_buffered = 1'b1;
    m_second_upper = m_forward;  // Forward takes low half first
    return m_forward ? m_word[15:0] : m_word[31:16];
  endfunction

  function automatic period_t next_period(input period_t p, input bit up, input bit down);
    if (up)
      return (int'(p) - int'(STEP) < int'(MIN_P)) ? MIN_P : p - STEP;
    if (down)
      return (int'(p) + int'(STEP) > int'(MAX_P)) ? MAX_P : p + STEP;
    return DEF_PERIOD;
  endfunction

  function automatic seg_t seg_of(input logic [3:0] n);
    seg_t pat[16];
    pat = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
            7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
    return pat[n];
  endfunction

  // ====================
  // Reporting and tasks
  // ====================

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Run stopped at first failure");
  endtask

  task automatic check_display(input period_t p);
    logic [23:0] v;
    seg_t        got[6];
    v = {8'h00, p};
    got = '{hex0, hex1, hex2, hex3, hex4, hex5};
    for (int i = 0; i < 6; i++)
    begin
      assert (got[i] == seg_of(v[4*i +: 4]))
      else
        fail_run($sformatf("** Error [%0t] hex%0d shows %h, expected digit %h",
                           $time, i, got[i], v[4*i +: 4]));
    end
  endtask

  task automatic send_cmd(input ascii_t c);
    @(posedge CLK_50M);
    #2;
    kbd_code = c;
    kbd_strobe = 1'b1;
    @(posedge CLK_50M);
    #2;
    kbd_strobe = 1'b0;
    if (c == CMD_FWD)
      m_forward = 1'b1;
    else if (c == CMD_BWD)
      m_forward = 1'b0;
    else if (c == CMD_RESTART)
      m_rst_pend = 1'b1;
  endtask

  task automatic play_samples(input int n);
    int target;
    target = valid_count + n;
    while (valid_count < target)
      @(posedge CLK_50M);
  endtask

  // Lets the last request drain, then expects silence
  task automatic pause_and_hold();
    int snap;
    send_cmd(CMD_PAUSE);
    repeat (2 * int'(DEF_PERIOD)) @(posedge CLK_50M);
    snap = valid_count;
    repeat (4 * int'(DEF_PERIOD)) @(posedge CLK_50M);
    assert (valid_count == snap)
    else
      fail_run($sformatf("** Error [%0t] %0d samples appeared while paused",
                         $time, valid_count - snap));
  endtask

  task automatic speed_pulse(input bit up, input bit down);
    @(posedge CLK_50M);
    #2;
    speed_up = up;
    speed_down = down;
    speed_reset = !up && !down;
    @(posedge CLK_50M);
    #2;
    speed_up = 1'b0;
    speed_down = 1'b0;
    speed_reset = 1'b0;
    exp_period = next_period(exp_period, up, down);
    repeat (REFRESH + 1) @(posedge CLK_50M);
    check_display(exp_period);
  endtask

  // ====================
  // Flash model
  // ====================

  initial
  begin
    flash_addr_t a;
    int          n;
    forever
    begin
      @(posedge CLK_50M);
      #2;
      if (flash_read)
      begin
        a = flash_address;
        repeat (rand_bits(2)) @(posedge CLK_50M);  // Waitrequest stays high
        #2;
        flash_waitrequest = 1'b0;
        @(posedge CLK_50M);
        #2;
        flash_waitrequest = 1'b1;
        n = rand_bits(4) % 9;  // Latency 0 to 8
        repeat (n) @(posedge CLK_50M);
        #2;
        flash_readdatavalid = 1'b1;
        flash_readdata = flash_word(a);
        @(posedge CLK_50M);
        #2;
        flash_readdatavalid = 1'b0;
        flash_readdata = '0;
      end
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge CLK_50M)
  begin
    sample_t exp;
    if (rst_n && audio_valid)
    begin
      exp = expected_sample();
      assert (audio_sample == exp)
      else
        fail_run($sformatf("** Error [%0t] sample %0d is %h, expected %h (word %0d)",
                           $time, valid_count, audio_sample, exp, m_addr));
      valid_count++;
    end
  end

  initial
  begin
    #(WATCHDOG_NS * 1ns);
    fail_run("Watchdog timeout, the tests did not finish in the expected time");
  end

  // ====================
  // Stimulus
  // ====================

  initial
  begin
    rst_n = 1'b0;
    kbd_code = '0;
    kbd_strobe = 1'b0;
    speed_up = 1'b0;
    speed_down = 1'b0;
    speed_reset = 1'b0;
    flash_waitrequest = 1'b1;
    flash_readdatavalid = 1'b0;
    flash_readdata = '0;
    repeat (5) @(posedge CLK_50M);
    #2;
    rst_n = 1'b1;

    check_display(16'd0);
    repeat (3 * int'(DEF_PERIOD))
    begin
      @(negedge CLK_50M);
      assert (!flash_read && !audio_valid)
      else
        fail_run($sformatf("** Error [%0t] bus activity while paused after reset", $time));
    end
    check_display(DEF_PERIOD);

    send_cmd(CMD_PLAY);  // Forward through the wrap
    play_samples(WRAP_SAMPLES);
    pause_and_hold();
    send_cmd(CMD_PLAY);
    play_samples(8);

    pause_and_hold();
    send_cmd(CMD_BWD);
    send_cmd(CMD_PLAY);
    play_samples(WRAP_SAMPLES);

    pause_and_hold();
    send_cmd(CMD_RESTART);
    send_cmd(CMD_PLAY);
    play_samples(RESTART_SAMPLES);
    pause_and_hold();
    send_cmd(CMD_FWD);
    send_cmd(CMD_RESTART);
    send_cmd(CMD_PLAY);
    play_samples(RESTART_SAMPLES);
    pause_and_hold();

    repeat (6) speed_pulse(1'b1, 1'b0);  // Down to the clamp
    speed_pulse(1'b0, 1'b0);
    repeat (13) speed_pulse(1'b0, 1'b1);
    speed_pulse(1'b0, 1'b0);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/hex_display.sv
`default_nettype none

module hex_display
  import ipod_pkg::*;
#(
  parameter int REFRESH_CYCLES = 25_000_000
)
(
  input  wire     CLK_50M,
  input  wire     rst_n,
  input  period_t sample_period,
  output seg_t    hex0,
  output seg_t    hex1,
  output seg_t    hex2,
  output seg_t    hex3,
  output seg_t    hex4,
  output seg_t    hex5
);

  localparam int CNT_W = $clog2(REFRESH_CYCLES);

  logic [CNT_W-1:0] refresh_cnt;
  logic [23:0]      disp_val;  // Six hex digits

  // Active-low patterns in gfedcba order
  function automatic seg_t seg_decode(input logic [3:0] nib);
    case (nib)
      4'h0: seg_decode = 7'b1000000;
      4'h1: seg_decode = 7'b1111001;
      4'h2: seg_decode = 7'b0100100;
      4'h3: seg_decode = 7'b0110000;
      4'h4: seg_decode = 7'b0011001;
      4'h5: seg_decode = 7'b0010010;
      4'h6: seg_decode = 7'b0000010;
      4'h7: seg_decode = 7'b1111000;
      4'h8: seg_decode = 7'b0000000;
      4'h9: seg_decode = 7'b0010000;
      4'hA: seg_decode = 7'b0001000;
      4'hB: seg_decode = 7'b0000011;
      4'hC: seg_decode = 7'b1000110;
      4'hD: seg_decode = 7'b0100001;
      4'hE: seg_decode = 7'b0000110;
      default: seg_decode = 7'b0001110;  // F
    endcase
  endfunction

  // Slow refresh keeps the digits readable while the period moves
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      refresh_cnt <= '0;
      disp_val    <= '0;
    end
    else if (refresh_cnt == CNT_W'(REFRESH_CYCLES - 1))
    begin
      refresh_cnt <= '0;
      disp_val    <= {8'h00, sample_period};
    end
    else
      refresh_cnt <= refresh_cnt + 1'b1;
  end

  assign hex0 = seg_decode(disp_val[3:0]);  // Least significant
  assign hex1 = seg_decode(disp_val[7:4]);
  assign hex2 = seg_decode(disp_val[11:8]);
  assign hex3 = seg_decode(disp_val[15:12]);
  assign hex4 = seg_decode(disp_val[19:16]);
  assign hex5 = seg_decode(disp_val[23:20]);

endmodule

`default_nettype wire

//--- hdl/ipod_pkg.sv
`default_nettype none

package ipod_pkg;

  // ====================
  // Widths and vector types
  // ====================

  localparam int ADDR_W = 23;  // Flash word address bits

  typedef logic [ADDR_W-1:0] flash_addr_t;
  typedef logic [31:0]       flash_word_t;  // Two samples per word
  typedef logic [15:0]       sample_t;      // Signed audio sample
  typedef logic [15:0]       period_t;      // Clock cycles per sample
  typedef logic [7:0]        ascii_t;
  typedef logic [6:0]        seg_t;         // Active low, bit 0 = a

  // ====================
  // Player state
  // ====================

  typedef enum logic
  {
    ST_PAUSED  = 1'b0,
    ST_PLAYING = 1'b1
  } play_state_t;

  // ====================
  // Keyboard commands
  // ====================

  localparam ascii_t CMD_PLAY    = 8'h45;  // 'E'
  localparam ascii_t CMD_PAUSE   = 8'h44;  // 'D'
  localparam ascii_t CMD_FWD     = 8'h46;  // 'F'
  localparam ascii_t CMD_BWD     = 8'h42;  // 'B'
  localparam ascii_t CMD_RESTART = 8'h52;  // 'R'

endpackage

`default_nettype wire

//--- hdl/player_ctrl.sv
`default_nettype none

module player_ctrl
  import ipod_pkg::*;
(
  input  wire    CLK_50M,
  input  wire    rst_n,
  input  ascii_t kbd_code,
  input  wire    kbd_strobe,
  input  wire    sample_tick,
  output logic   fetch_req,
  output logic   forward,
  output logic   restart
);

  play_state_t state;
  play_state_t state_nxt;

  // ====================
  // Play / pause FSM
  // ====================

  always_comb
  begin
    state_nxt = state;
    if (kbd_strobe)
    begin
      case (state)
        ST_PAUSED:
        begin
          if (kbd_code == CMD_PLAY)
            state_nxt = ST_PLAYING;
        end
        ST_PLAYING:
        begin
          if (kbd_code == CMD_PAUSE)
            state_nxt = ST_PAUSED;
        end
        default: state_nxt = ST_PAUSED;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      state <= ST_PAUSED;
    else
      state <= state_nxt;
  end

  // Direction and restart commands are independent of play state
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      forward <= 1'b1;
      restart <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (kbd_strobe)
      begin
        case (kbd_code)
          CMD_FWD:     forward <= 1'b1;
          CMD_BWD:     forward <= 1'b0;
          CMD_RESTART: restart <= 1'b1;  // Single cycle
          default:     ;                 // Anything else ignored
        endcase
      end
    end
  end

  // Sample strobe only reaches the fetcher while playing
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      fetch_req <= 1'b0;
    else
      fetch_req <= sample_tick && (state == ST_PLAYING);
  end

endmodule

`default_nettype wire

//--- hdl/rate_gen.sv
`default_nettype none

module rate_gen
  import ipod_pkg::*;
#(
  parameter period_t DEFAULT_PERIOD = 16'd2272,
  parameter period_t SPEED_STEP     = 16'd16,
  parameter period_t MIN_PERIOD     = 16'd64,
  parameter period_t MAX_PERIOD     = 16'd8192
)
(
  input  wire     CLK_50M,
  input  wire     rst_n,
  input  wire     speed_up,
  input  wire     speed_down,
  input  wire     speed_reset,
  output period_t sample_period,
  output logic    sample_tick
);

  period_t tick_cnt;

  // ====================
  // Period register
  // ====================

  // Shorter period means faster playback
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      sample_period <= DEFAULT_PERIOD;
    else if (speed_reset)
      sample_period <= DEFAULT_PERIOD;
    else if (speed_up)
    begin
      if (sample_period < MIN_PERIOD + SPEED_STEP)
        sample_period <= MIN_PERIOD;  // Clamp low
      else
        sample_period <= sample_period - SPEED_STEP;
    end
    else if (speed_down)
    begin
      if (sample_period > MAX_PERIOD - SPEED_STEP)
        sample_period <= MAX_PERIOD;  // Clamp high
      else
        sample_period <= sample_period + SPEED_STEP;
    end
  end

  // ====================
  // Sample strobe divider
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      tick_cnt    <= DEFAULT_PERIOD - period_t'(1);
      sample_tick <= 1'b0;
    end
    else if (tick_cnt == '0)
    begin
      tick_cnt    <= sample_period - period_t'(1);  // New period picked up here
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt    <= tick_cnt - period_t'(1);
      sample_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/sample_fetch.sv
`default_nettype none

module sample_fetch
  import ipod_pkg::*;
#(
  parameter flash_addr_t SONG_LAST_ADDR = 23'h7FFFF
)
(
  input  wire         CLK_50M,
  input  wire         rst_n,
  input  wire         fetch_req,
  input  wire         forward,
  input  wire         restart,
  output logic        flash_read,
  output flash_addr_t flash_address,
  input  wire         flash_waitrequest,
  input  flash_word_t flash_readdata,
  input  wire         flash_readdatavalid,
  output sample_t     audio_sample,
  output logic        audio_valid
);

  typedef enum logic [1:0]
  {
    FS_IDLE,  // No read in flight
    FS_REQ,   // Read raised, waiting for waitrequest low
    FS_WAIT   // Read accepted, waiting for data
  } fetch_state_t;

  fetch_state_t state;
  flash_addr_t  cur_addr;    // Address of the last word fetched
  flash_addr_t  fetch_addr;
  flash_word_t  word_buf;
  logic         buf_valid;   // Second half still unplayed
  logic         half_sel;    // 1 = upper half is next
  logic         rd_fwd;      // Direction the word in flight was fetched with
  logic         rst_pend;    // Restart waiting for the next fetch
  logic         pend;        // One-deep request queue
  logic         want;
  logic         serve_buf;
  logic         data_ret;
  logic         take_word;
  logic         issue;

  assign flash_address = cur_addr;  // Held steady through the whole read

  // ====================
  // Next word address
  // ====================

  always_comb
  begin
    if (rst_pend)
      fetch_addr = forward ? '0 : SONG_LAST_ADDR;
    else if (forward)
      fetch_addr = (cur_addr == SONG_LAST_ADDR) ? '0 : cur_addr + flash_addr_t'(1);
    else
      fetch_addr = (cur_addr == '0) ? SONG_LAST_ADDR : cur_addr - flash_addr_t'(1);
  end

  // Readdatavalid is expected at least one cycle after acceptance
  assign want      = fetch_req || pend;
  assign serve_buf = (state == FS_IDLE) && want && buf_valid;
  assign data_ret  = (state == FS_WAIT) && flash_readdatavalid;
  assign take_word = data_ret && !rst_pend;
  // A word returned under a restart is dropped and refetched at once
  assign issue     = ((state == FS_IDLE) && want && !buf_valid) || (data_ret && rst_pend);

  // ====================
  // Control
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state       <= FS_IDLE;
      flash_read  <= 1'b0;
      cur_addr    <= '0;
      rd_fwd      <= 1'b1;
      rst_pend    <= 1'b1;  // First fetch starts at the song edge
      buf_valid   <= 1'b0;
      half_sel    <= 1'b0;
      pend        <= 1'b0;
      audio_valid <= 1'b0;
    end
    else
    begin
      audio_valid <= serve_buf || take_word;

      if (serve_buf)
        buf_valid <= 1'b0;
      if (take_word)
      begin
        buf_valid <= 1'b1;
        half_sel  <= rd_fwd;  // Forward plays low then high
      end

      if (issue)
      begin
        cur_addr   <= fetch_addr;
        rd_fwd     <= forward;
        rst_pend   <= 1'b0;
        flash_read <= 1'b1;
        state      <= FS_REQ;
      end
      else if ((state == FS_REQ) && !flash_waitrequest)
      begin
        flash_read <= 1'b0;
        state      <= FS_WAIT;
      end
      else if (take_word)
        state <= FS_IDLE;

      // Idle consumes one request per cycle, busy queues one
      if (state == FS_IDLE)
        pend <= pend && fetch_req;
      else if (fetch_req)
        pend <= 1'b1;

      if (restart)
        rst_pend <= 1'b1;
    end
  end

  // ====================
  // Sample datapath
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (take_word)
    begin
      word_buf     <= flash_readdata;
      audio_sample <= rd_fwd ? flash_readdata[15:0] : flash_readdata[31:16];
    end
    else if (serve_buf)
      audio_sample <= half_sel ? word_buf[31:16] : word_buf[15:0];
  end

endmodule

`default_nettype wire

//--- hdl/simple_ipod.sv
`default_nettype none

module simple_ipod
  import ipod_pkg::*;
#(
  parameter flash_addr_t SONG_LAST_ADDR = 23'h7FFFF,
  parameter period_t     DEFAULT_PERIOD = 16'd2272,
  parameter period_t     SPEED_STEP     = 16'd16,
  parameter period_t     MIN_PERIOD     = 16'd64,
  parameter period_t     MAX_PERIOD     = 16'd8192,
  parameter int          REFRESH_CYCLES = 25_000_000
)
(
  input  wire         CLK_50M,
  input  wire         rst_n,
  input  ascii_t      kbd_code,
  input  wire         kbd_strobe,
  input  wire         speed_up,
  input  wire         speed_down,
  input  wire         speed_reset,
  output logic        flash_read,
  output flash_addr_t flash_address,
  input  wire         flash_waitrequest,
  input  wire         flash_readdatavalid,
  input  flash_word_t flash_readdata,
  output sample_t     audio_sample,
  output logic        audio_valid,
  output seg_t        hex0,
  output seg_t        hex1,
  output seg_t        hex2,
  output seg_t        hex3,
  output seg_t        hex4,
  output seg_t        hex5
);

  period_t sample_period;
  logic    sample_tick;
  logic    fetch_req;
  logic    forward;
  logic    restart;

  // ====================
  // Playback path
  // ====================

  player_ctrl u_player_ctrl (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .kbd_code    (kbd_code),
    .kbd_strobe  (kbd_strobe),
    .sample_tick (sample_tick),
    .fetch_req   (fetch_req),
    .forward     (forward),
    .restart     (restart)
  );

  sample_fetch #(
    .SONG_LAST_ADDR (SONG_LAST_ADDR)
  ) u_sample_fetch (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .fetch_req           (fetch_req),
    .forward             (forward),
    .restart             (restart),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .audio_valid         (audio_valid)
  );

  // ====================
  // Speed and display
  // ====================

  rate_gen #(
    .DEFAULT_PERIOD (DEFAULT_PERIOD),
    .SPEED_STEP     (SPEED_STEP),
    .MIN_PERIOD     (MIN_PERIOD),
    .MAX_PERIOD     (MAX_PERIOD)
  ) u_rate_gen (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_reset   (speed_reset),
    .sample_period (sample_period),
    .sample_tick   (sample_tick)
  );

  hex_display #(
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) u_hex_display (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .sample_period (sample_period),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the simulation, exit status follows the result
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_simple_ipod \
  -f sim.f -o Vtb_simple_ipod \
  && ./obj_dir/Vtb_simple_ipod \
  || exit 1

exit 0

//--- sim.f
hdl/ipod_pkg.sv
hdl/player_ctrl.sv
hdl/sample_fetch.sv
hdl/rate_gen.sv
hdl/hex_display.sv
hdl/simple_ipod.sv
dv/ipod_sva.sv
dv/tb_simple_ipod.sv
